/* tb.f */
common/isa_pkg.sv
common/core_pkg.sv
core/reg_file.sv
core/id_stage.sv
core/ex_stage.sv
hdl/mips_core.sv
sim/mips_core_assert.sv
sim/tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - files:
      - common/isa_pkg.sv
      - common/core_pkg.sv
      - core/reg_file.sv
      - core/id_stage.sv
      - core/ex_stage.sv
      - hdl/mips_core.sv
  - target: simulation
    files:
      - sim/mips_core_assert.sv
      - sim/tb_mips_core.sv

/* sim/tb_mips_core.sv */
module tb_mips_core
	import isa_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_random = 400;
	// reset, directed phase, random stream with up to 3 bubbles each, drain
	localparam int max_cycles = 8 + 150 + n_random * 4 + 20;
	localparam int timeout_ns = max_cycles * 8 + 2000;

	logic        clk;
	logic        rst_n;
	logic        inst_valid;
	logic [31:0] inst;
	logic        wb_valid;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;

	logic [31:0] model_regs [0:31];
	logic [4:0]  exp_addr_q [$];
	logic [31:0] exp_data_q [$];
	string       exp_name_q [$];

	mips_core uut (.clk, .rst_n, .inst_valid, .inst, .wb_valid, .wb_addr, .wb_data);

	function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		inst_t w;
		w.r = '{op_special, rs, rt, rd, shamt, funct};
		return w;
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		inst_t w;
		w.i = '{op, rs, rt, imm};
		return w;
	endfunction

	// executes one word on the model registers
	function automatic void ref_exec(input inst_t w, output logic has_wb,
		output logic [4:0] addr, output logic [31:0] data);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] zext;
		a = model_regs[w.r.rs];
		b = model_regs[w.r.rt];
		sext = {{16{w.i.imm[15]}}, w.i.imm};
		zext = {16'h0, w.i.imm};
		has_wb = 1'b1;
		addr = w.i.rt;
		data = '0;
		case (w.r.op)
			op_special:
			begin
				addr = w.r.rd;
				case (w.r.funct)
					fn_addu: data = a + b;
					fn_subu: data = a - b;
					fn_and:  data = a & b;
					fn_or:   data = a | b;
					fn_xor:  data = a ^ b;
					fn_slt:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					fn_sltu: data = (a < b) ? 32'd1 : 32'd0;
					fn_sll:  data = b << w.r.shamt;
					fn_srl:  data = b >> w.r.shamt;
					fn_sra:  data = $signed(b) >>> w.r.shamt;
					default: has_wb = 1'b0;
				endcase
			end
			op_addiu: data = a + sext;
			op_slti:  data = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
			op_andi:  data = a & zext;
			op_ori:   data = a | zext;
			op_xori:  data = a ^ zext;
			op_lui:   data = {w.i.imm, 16'h0};
			default:  has_wb = 1'b0;
		endcase
		// r0 is hardwired to zero
		if (addr == 5'd0)
			has_wb = 1'b0;
		if (has_wb)
			model_regs[addr] = data;
	endfunction

	function automatic logic [31:0] random_word();
		logic [5:0] functs [10] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor,
			fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra};
		logic [5:0] iops [6] = '{op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui};
		// only r0..r7 so that hazards are frequent
		if ($urandom_range(0, 1) == 1)
			return rtype_word(functs[$urandom_range(0, 9)], 5'($urandom_range(0, 7)),
				5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)), 5'($urandom));
		else
			return itype_word(iops[$urandom_range(0, 5)], 5'($urandom_range(0, 7)),
				5'($urandom_range(0, 7)), 16'($urandom));
	endfunction

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic issue(input string name, input logic [31:0] word);
		logic        has_wb;
		logic [4:0]  addr;
		logic [31:0] data;
		@(posedge clk);
		#1;
		inst_valid = 1'b1;
		inst = word;
		ref_exec(word, has_wb, addr, data);
		if (has_wb)
		begin
			exp_addr_q.push_back(addr);
			exp_data_q.push_back(data);
			exp_name_q.push_back(name);
		end
	endtask

	// idle cycles carry a random word that must be ignored
	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			#1;
			inst_valid = 1'b0;
			inst = $urandom;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		#(timeout_ns);
		$display("Timeout after %0d ns, the writeback stream never finished", timeout_ns);
		abort_run();
	end

	initial
	begin
		wait (uut.u_assert.fail_count != 0);
		$display("A bound assertion on the writeback strobe failed");
		abort_run();
	end

	initial
	begin
		string       name;
		logic [4:0]  addr;
		logic [31:0] data;
		forever
		begin
			@(negedge clk);
			if (rst_n && wb_valid)
			begin
				if (exp_addr_q.size() == 0)
				begin
					$display("Unexpected wb_valid at %0t for register %0d", $time, wb_addr);
					abort_run();
				end
				else
				begin
					name = exp_name_q.pop_front();
					addr = exp_addr_q.pop_front();
					data = exp_data_q.pop_front();
					check_value({name, " addr"}, {27'h0, addr}, {27'h0, wb_addr});
					check_value({name, " data"}, data, wb_data);
				end
			end
		end
	end

	initial
	begin
		void'($urandom(32'h3c0f));
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		idle(2);

		issue("imm addiu pos", itype_word(op_addiu, 1, 0, 16'h1234));
		issue("imm addiu neg", itype_word(op_addiu, 2, 0, 16'hfffb));
		idle(3);
		issue("imm andi", itype_word(op_andi, 3, 2, 16'h8f0f));
		issue("imm ori", itype_word(op_ori, 4, 1, 16'h8000));
		issue("imm xori", itype_word(op_xori, 5, 2, 16'hffff));
		issue("imm slti true", itype_word(op_slti, 6, 2, 16'h0001));
		issue("imm slti false", itype_word(op_slti, 7, 1, 16'hffff));
		issue("imm lui", itype_word(op_lui, 8, 0, 16'h8765));
		issue("imm addiu sext", itype_word(op_addiu, 9, 2, 16'h8000));
		idle(3);

		issue("alu seed neg", itype_word(op_addiu, 10, 0, 16'hfff9));
		issue("alu seed pos", itype_word(op_addiu, 11, 0, 16'h0003));
		issue("alu seed min", itype_word(op_lui, 12, 0, 16'h8000));
		idle(3);
		issue("alu addu", rtype_word(fn_addu, 13, 10, 11, 0));
		issue("alu subu", rtype_word(fn_subu, 14, 11, 10, 0));
		issue("alu and", rtype_word(fn_and, 15, 10, 11, 0));
		issue("alu or", rtype_word(fn_or, 16, 10, 11, 0));
		issue("alu xor", rtype_word(fn_xor, 17, 10, 11, 0));
		issue("alu slt neg", rtype_word(fn_slt, 18, 10, 11, 0));
		issue("alu sltu neg", rtype_word(fn_sltu, 19, 10, 11, 0));
		issue("alu slt pos", rtype_word(fn_slt, 20, 11, 10, 0));
		issue("alu sltu pos", rtype_word(fn_sltu, 21, 11, 10, 0));
		issue("alu slt min", rtype_word(fn_slt, 22, 12, 11, 0));
		idle(3);

		issue("shift sll", rtype_word(fn_sll, 23, 0, 10, 4));
		issue("shift srl", rtype_word(fn_srl, 24, 0, 10, 4));
		issue("shift sra", rtype_word(fn_sra, 25, 0, 10, 4));
		issue("shift sra 31", rtype_word(fn_sra, 26, 0, 12, 31));
		issue("shift srl 31", rtype_word(fn_srl, 27, 0, 12, 31));
		issue("shift sll 31", rtype_word(fn_sll, 28, 0, 11, 31));
		issue("shift sll 0", rtype_word(fn_sll, 29, 0, 11, 0));
		idle(3);

		issue("fwd1 seed", itype_word(op_addiu, 1, 0, 16'd5));
		issue("fwd1 addu", rtype_word(fn_addu, 2, 1, 1, 0));
		issue("fwd1 subu", rtype_word(fn_subu, 3, 2, 1, 0));
		issue("fwd1 sll", rtype_word(fn_sll, 4, 0, 3, 2));
		issue("fwd1 xor", rtype_word(fn_xor, 5, 4, 3, 0));
		idle(2);
		issue("fwd2 seed a", itype_word(op_addiu, 6, 0, 16'h0010));
		issue("fwd2 seed b", itype_word(op_ori, 7, 0, 16'h0003));
		issue("fwd2 addu", rtype_word(fn_addu, 8, 6, 6, 0));
		issue("fwd2 subu", rtype_word(fn_subu, 9, 7, 8, 0));
		issue("fwd prio old", itype_word(op_addiu, 10, 0, 16'd7));
		issue("fwd prio new", itype_word(op_addiu, 10, 0, 16'd9));
		issue("fwd prio use", rtype_word(fn_addu, 11, 10, 10, 0));
		issue("fwd sra", rtype_word(fn_sra, 12, 0, 9, 1));
		idle(3);

		issue("r0 addiu", itype_word(op_addiu, 0, 0, 16'h0055));
		issue("r0 read", rtype_word(fn_or, 13, 0, 0, 0));
		issue("r0 addu", rtype_word(fn_addu, 0, 1, 2, 0));
		issue("bad opcode", itype_word(6'h23, 14, 0, 16'h0040));
		issue("bad funct", rtype_word(6'h08, 15, 1, 0, 0));
		issue("r0 after", rtype_word(fn_addu, 16, 0, 0, 0));
		issue("bad dest read", rtype_word(fn_or, 17, 14, 15, 0));
		idle(4);

		for (int n = 0; n < n_random; n++)
		begin
			issue($sformatf("random %0d", n), random_word());
			if ($urandom_range(0, 3) == 0)
				idle($urandom_range(1, 3));
		end
		idle(6);

		if (exp_addr_q.size() != 0)
		begin
			$display("%0d expected writebacks never arrived", exp_addr_q.size());
			abort_run();
		end
		else
		begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

/* sim/mips_core_assert.sv */
module mips_core_assert
	import isa_pkg::*;
(
	input logic        clk,
	input logic        rst_n,
	input logic        inst_valid,
	input logic [31:0] inst,
	input logic        wb_valid,
	input logic [4:0]  wb_addr
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0;

	// supported word with a nonzero destination
	function automatic logic writes_reg(input inst_t w);
		case (w.r.op)
			op_special:
				return w.r.rd != 5'd0 && w.r.funct inside {fn_sll, fn_srl, fn_sra, fn_addu,
					fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_sltu};
			op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui:
				return w.i.rt != 5'd0;
			default:
				return 1'b0;
		endcase
	endfunction

	reset_quiet: assert property (@(posedge clk) !rst_n |-> !wb_valid)
		else
		begin
			$error("wb_valid high during reset");
			fail_count++;
		end

	release_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !wb_valid ##1 !wb_valid)
		else
		begin
			$error("wb_valid high within two cycles of reset release");
			fail_count++;
		end

	strobe_latency: assert property (@(posedge clk) disable iff (!rst_n)
		inst_valid && writes_reg(inst) |-> ##2 wb_valid)
		else
		begin
			$error("writing instruction gave no wb_valid two cycles later");
			fail_count++;
		end

	no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> wb_addr != 5'd0)
		else
		begin
			$error("writeback strobe addressed register 0");
			fail_count++;
		end

endmodule

bind mips_core mips_core_assert u_assert (.*);

/* hdl/mips_core.sv */
module mips_core
	import core_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  inst_valid,
	input  logic [xlen-1:0]       inst,
	output logic                  wb_valid,
	output logic [reg_addr_w-1:0] wb_addr,
	output logic [xlen-1:0]       wb_data
);

	logic [reg_addr_w-1:0] raddr_a;
	logic [reg_addr_w-1:0] raddr_b;
	logic [xlen-1:0]       rdata_a;
	logic [xlen-1:0]       rdata_b;

	logic                  dec_valid;
	logic [alu_op_w-1:0]   dec_op;
	logic [xlen-1:0]       dec_a;
	logic [xlen-1:0]       dec_b;
	logic [reg_addr_w-1:0] dec_dest;
	logic [xlen-1:0]       ex_result;

	reg_file u_reg_file (
		.clk,
		.rst_n,
		.we(wb_valid),
		.waddr(wb_addr),
		.wdata(wb_data),
		.raddr_a,
		.raddr_b,
		.rdata_a,
		.rdata_b
	);

	id_stage u_id_stage (
		.clk,
		.rst_n,
		.inst_valid,
		.inst,
		.raddr_a,
		.raddr_b,
		.rdata_a,
		.rdata_b,
		// two forward sources
		.ex_result,
		.wb_valid,
		.wb_addr,
		.wb_data,
		.dec_valid,
		.dec_op,
		.dec_a,
		.dec_b,
		.dec_dest
	);

	ex_stage u_ex_stage (
		.clk,
		.rst_n,
		.dec_valid,
		.dec_op,
		.dec_a,
		.dec_b,
		.dec_dest,
		.ex_result,
		.wb_valid,
		.wb_addr,
		.wb_data
	);

endmodule

/* core/ex_stage.sv */
module ex_stage
	import core_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  dec_valid,
	input  logic [alu_op_w-1:0]   dec_op,
	input  logic [xlen-1:0]       dec_a,
	input  logic [xlen-1:0]       dec_b,
	input  logic [reg_addr_w-1:0] dec_dest,
	output logic [xlen-1:0]       ex_result,
	output logic                  wb_valid,
	output logic [reg_addr_w-1:0] wb_addr,
	output logic [xlen-1:0]       wb_data
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = dec_b[4:0];
	assign lt_signed   = $signed(dec_a) < $signed(dec_b);
	assign lt_unsigned = dec_a < dec_b;

	always_comb
	begin
		case (dec_op)
			alu_add:  ex_result = dec_a + dec_b;
			alu_sub:  ex_result = dec_a - dec_b;
			alu_and:  ex_result = dec_a & dec_b;
			alu_or:   ex_result = dec_a | dec_b;
			alu_xor:  ex_result = dec_a ^ dec_b;
			alu_slt:  ex_result = {{(xlen-1){1'b0}}, lt_signed};
			alu_sltu: ex_result = {{(xlen-1){1'b0}}, lt_unsigned};
			alu_sll:  ex_result = dec_a << shamt;
			alu_srl:  ex_result = dec_a >> shamt;
			alu_sra:  ex_result = $unsigned($signed(dec_a) >>> shamt);
			// immediate sits zero-extended in the low half
			alu_lui:  ex_result = {dec_b[15:0], 16'b0};
			default:  ex_result = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wb_valid <= 1'b0;
			wb_addr  <= '0;
			wb_data  <= '0;
		end
		else
		begin
			wb_valid <= dec_valid;
			if (dec_valid)
			begin
				wb_addr <= dec_dest;
				wb_data <= ex_result;
			end
		end
	end

endmodule

/* core/id_stage.sv */
module id_stage
	import core_pkg::*;
	import isa_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  inst_valid,
	input  inst_t                 inst,
	output logic [reg_addr_w-1:0] raddr_a,
	output logic [reg_addr_w-1:0] raddr_b,
	input  logic [xlen-1:0]       rdata_a,
	input  logic [xlen-1:0]       rdata_b,
	input  logic [xlen-1:0]       ex_result,
	input  logic                  wb_valid,
	input  logic [reg_addr_w-1:0] wb_addr,
	input  logic [xlen-1:0]       wb_data,
	output logic                  dec_valid,
	output logic [alu_op_w-1:0]   dec_op,
	output logic [xlen-1:0]       dec_a,
	output logic [xlen-1:0]       dec_b,
	output logic [reg_addr_w-1:0] dec_dest
);

	logic [alu_op_w-1:0]   op_sel;
	logic                  known;
	logic                  use_imm;
	logic                  sign_ext;
	logic                  is_shift;
	logic [reg_addr_w-1:0] dest;
	logic [xlen-1:0]       imm_ext;
	logic [xlen-1:0]       fwd_a;
	logic [xlen-1:0]       fwd_b;
	logic [xlen-1:0]       op_a;
	logic [xlen-1:0]       op_b;

	// youngest producer wins, then writeback, then the register file
	function automatic logic [xlen-1:0] fwd_pick(
		input logic [reg_addr_w-1:0] addr,
		input logic [xlen-1:0]       rf_val
	);
		if (dec_valid && dec_dest == addr)
			return ex_result;
		else if (wb_valid && wb_addr == addr)
			return wb_data;
		else
			return rf_val;
	endfunction

	assign raddr_a = inst.r.rs;
	assign raddr_b = inst.r.rt;

	always_comb
	begin
		op_sel   = alu_add;
		known    = 1'b1;
		use_imm  = 1'b1;
		sign_ext = 1'b0;
		is_shift = 1'b0;
		dest     = inst.i.rt;
		case (inst.r.op)
			op_special:
			begin
				use_imm = 1'b0;
				dest    = inst.r.rd;
				case (inst.r.funct)
					fn_addu: op_sel = alu_add;
					fn_subu: op_sel = alu_sub;
					fn_and:  op_sel = alu_and;
					fn_or:   op_sel = alu_or;
					fn_xor:  op_sel = alu_xor;
					fn_slt:  op_sel = alu_slt;
					fn_sltu: op_sel = alu_sltu;
					fn_sll:
					begin
						op_sel   = alu_sll;
						is_shift = 1'b1;
					end
					fn_srl:
					begin
						op_sel   = alu_srl;
						is_shift = 1'b1;
					end
					fn_sra:
					begin
						op_sel   = alu_sra;
						is_shift = 1'b1;
					end
					default: known = 1'b0;
				endcase
			end
			op_addiu:
			begin
				op_sel   = alu_add;
				sign_ext = 1'b1;
			end
			op_slti:
			begin
				op_sel   = alu_slt;
				sign_ext = 1'b1;
			end
			op_andi: op_sel = alu_and;
			op_ori:  op_sel = alu_or;
			op_xori: op_sel = alu_xor;
			op_lui:  op_sel = alu_lui;
			default: known = 1'b0;
		endcase
	end

	always_comb
	begin
		fwd_a = fwd_pick(raddr_a, rdata_a);
		fwd_b = fwd_pick(raddr_b, rdata_b);
	end

	assign imm_ext = sign_ext ? {{16{inst.i.imm[15]}}, inst.i.imm} : {16'b0, inst.i.imm};

	// shifts operate on rt by shamt
	assign op_a = is_shift ? fwd_b : fwd_a;
	assign op_b = is_shift ? {{(xlen-5){1'b0}}, inst.r.shamt} :
		use_imm ? imm_ext : fwd_b;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			dec_valid <= 1'b0;
			dec_op    <= alu_add;
			dec_a     <= '0;
			dec_b     <= '0;
			dec_dest  <= '0;
		end
		else
		begin
			// writes to r0 are dropped here
			dec_valid <= inst_valid && known && (dest != '0);
			if (inst_valid)
			begin
				dec_op   <= op_sel;
				dec_a    <= op_a;
				dec_b    <= op_b;
				dec_dest <= dest;
			end
		end
	end

endmodule

/* core/reg_file.sv */
module reg_file
	import core_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  we,
	input  logic [reg_addr_w-1:0] waddr,
	input  logic [xlen-1:0]       wdata,
	input  logic [reg_addr_w-1:0] raddr_a,
	input  logic [reg_addr_w-1:0] raddr_b,
	output logic [xlen-1:0]       rdata_a,
	output logic [xlen-1:0]       rdata_b
);

	// r0 has no storage
	logic [xlen-1:0] regs [1:31];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 1; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (we)
		begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

/* common/core_pkg.sv */
package core_pkg;

	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int alu_op_w   = 4;

	// alu operation codes
	localparam logic [alu_op_w-1:0] alu_add  = 4'd0;
	localparam logic [alu_op_w-1:0] alu_sub  = 4'd1;
	localparam logic [alu_op_w-1:0] alu_and  = 4'd2;
	localparam logic [alu_op_w-1:0] alu_or   = 4'd3;
	localparam logic [alu_op_w-1:0] alu_xor  = 4'd4;
	localparam logic [alu_op_w-1:0] alu_slt  = 4'd5;
	localparam logic [alu_op_w-1:0] alu_sltu = 4'd6;
	localparam logic [alu_op_w-1:0] alu_sll  = 4'd7;
	localparam logic [alu_op_w-1:0] alu_srl  = 4'd8;
	localparam logic [alu_op_w-1:0] alu_sra  = 4'd9;
	localparam logic [alu_op_w-1:0] alu_lui  = 4'd10;

endpackage

/* common/isa_pkg.sv */
package isa_pkg;

	// primary opcodes
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_addiu   = 6'h09;
	localparam logic [5:0] op_slti    = 6'h0a;
	localparam logic [5:0] op_andi    = 6'h0c;
	localparam logic [5:0] op_ori     = 6'h0d;
	localparam logic [5:0] op_xori    = 6'h0e;
	localparam logic [5:0] op_lui     = 6'h0f;

	// funct codes under op_special
	localparam logic [5:0] fn_sll  = 6'h00;
	localparam logic [5:0] fn_srl  = 6'h02;
	localparam logic [5:0] fn_sra  = 6'h03;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_slt  = 6'h2a;
	localparam logic [5:0] fn_sltu = 6'h2b;

	// register format
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} inst_r_t;

	// immediate format
	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} inst_i_t;

	// same 32-bit word, two views
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_t;

endpackage
